// File: hdl/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define XLEN 32

// machine level CSRs
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEDELEG   12'h302
`define CSR_MIDELEG   12'h303
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// supervisor level CSRs
`define CSR_SSTATUS   12'h100
`define CSR_SIE       12'h104
`define CSR_STVEC     12'h105
`define CSR_SSCRATCH  12'h140
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143
`define CSR_SIP       12'h144

// custom timer compare registers
`define CSR_MNECYCLE  12'h7c0
`define CSR_SNECYCLE  12'h7c1

// exception codes
`define CAUSE_I_MISALIGNED 5'd0
`define CAUSE_ILLEGAL      5'd2
`define CAUSE_ECALL_S      5'd9
`define CAUSE_ECALL_M      5'd11

// interrupt codes
`define IRQ_S_TIMER   5'd5
`define IRQ_M_TIMER   5'd7
`define IRQ_S_EXT     5'd9
`define IRQ_M_EXT     5'd11

`define MISA_VALUE    32'h4004_1100 // rv32 with i, m and s
`define MEDELEG_MASK  32'h0000_ffff
`define MIDELEG_MASK  32'h0000_0222 // only s level interrupts delegate

`endif

// File: hdl/csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit import csr_pkg::*; (
	input logic clk, nrst,
	input logic csr_valid,
	input csr_op_t csr_op,
	input csr_addr_t csr_addr,
	input xlen_t csr_src,
	input xlen_t rd_data,		// old value, combinational from the register file
	output csr_addr_t rd_addr,
	output logic wr_en,
	output xlen_t wr_data,
	output xlen_t csr_rdata
	);

	logic src_zero;

	assign rd_addr = csr_addr;
	assign src_zero = (csr_src == '0);

	// instruction result is always the value before the write
	assign csr_rdata = rd_data;

	// read-modify-write data
	always_comb
	begin
		case (csr_op)
			CSR_RW:
				wr_data = csr_src;
			CSR_RS:
				wr_data = rd_data | csr_src;
			CSR_RC:
				wr_data = rd_data & ~csr_src;
			default:
				wr_data = rd_data;	// leave register as is
		endcase
	end

	// set or clear with x0 source must not write
	always_comb
	begin
		wr_en = 1'b0;
		if (csr_valid)
		begin
			if (csr_op == CSR_RW)
				wr_en = 1'b1;
			else
				wr_en = !src_zero;
		end
	end

	// a request must carry one of the three operations
	a_csr_op_known: assert property (
		@(posedge clk) disable iff (!nrst)
		csr_valid |-> (!$isunknown(csr_op) && csr_op inside {CSR_RW, CSR_RS, CSR_RC})
	) else $error("csr_op not a known operation while csr_valid is high");

endmodule

// File: hdl/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

	// register sized value
	typedef logic [`XLEN-1:0] xlen_t;

	typedef logic [11:0] csr_addr_t;

	// exception or interrupt code, without the interrupt flag
	typedef logic [4:0] cause_code_t;

	// low bits of funct3 for csrrw, csrrs, csrrc
	typedef enum logic [1:0]
	{
		CSR_RW = 2'b01,
		CSR_RS = 2'b10,
		CSR_RC = 2'b11
	} csr_op_t;

	// privilege levels, encoding as in mstatus.MPP
	typedef enum logic [1:0]
	{
		MODE_U = 2'b00,
		MODE_S = 2'b01,
		MODE_M = 2'b11
	} mode_t;

endpackage

// File: hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_regfile import csr_pkg::*; (
	input logic clk, nrst,
	input csr_addr_t rd_addr,
	output xlen_t rd_data,
	input logic wr_en,
	input xlen_t wr_data,
	input logic trap_enter, mret_do, sret_do,
	input logic trap_cause_irq,
	input cause_code_t trap_cause,
	input xlen_t trap_pc,
	input logic m_ext_irq, s_ext_irq,
	output xlen_t trap_vector, ret_pc_m, ret_pc_s,
	output logic [3:0] irq_pending,		// m ext, m timer, s ext, s timer
	output mode_t current_mode
	);

	// mstatus fields
	logic st_sie, st_mie, st_spie, st_mpie, st_spp;
	mode_t st_mpp;

	// mie fields
	logic meie, seie, mtie, stie;
	logic mtip, stip;

	logic [`XLEN-1:2] mtvec, stvec, mepc, sepc;	// low two bits hardwired zero
	xlen_t mscratch, sscratch;
	xlen_t mtval, stval;
	logic mcause_irq, scause_irq;
	cause_code_t mcause_code, scause_code;
	xlen_t medeleg, mideleg;
	xlen_t mnecycle, snecycle;
	xlen_t cycle_cnt;

	xlen_t mstatus, sstatus, mip, mie, sip, sie;
	logic trap_to_s;
	logic m_glob_en, s_glob_en;
	logic tval_pc;

	assign mstatus = {19'b0, st_mpp, 2'b0, st_spp, st_mpie, 1'b0, st_spie,
		1'b0, st_mie, 1'b0, st_sie, 1'b0};
	assign sstatus = {23'b0, st_spp, 2'b0, st_spie, 3'b0, st_sie, 1'b0};
	assign mip = {20'b0, m_ext_irq, 1'b0, s_ext_irq, 1'b0, mtip, 1'b0, stip, 5'b0};
	assign mie = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
	assign sip = {22'b0, s_ext_irq, 3'b0, stip, 5'b0};
	assign sie = {22'b0, seie, 3'b0, stie, 5'b0};

	always_comb
	begin
		case (rd_addr)
			`CSR_MSTATUS:	rd_data = mstatus;
			`CSR_MISA:	rd_data = `MISA_VALUE;
			`CSR_MEDELEG:	rd_data = medeleg;
			`CSR_MIDELEG:	rd_data = mideleg;
			`CSR_MIE:	rd_data = mie;
			`CSR_MTVEC:	rd_data = {mtvec, 2'b0};	// direct mode only
			`CSR_MSCRATCH:	rd_data = mscratch;
			`CSR_MEPC:	rd_data = {mepc, 2'b0};
			`CSR_MCAUSE:	rd_data = {mcause_irq, {(`XLEN-6){1'b0}}, mcause_code};
			`CSR_MTVAL:	rd_data = mtval;
			`CSR_MIP:	rd_data = mip;
			`CSR_SSTATUS:	rd_data = sstatus;
			`CSR_SIE:	rd_data = sie;
			`CSR_STVEC:	rd_data = {stvec, 2'b0};
			`CSR_SSCRATCH:	rd_data = sscratch;
			`CSR_SEPC:	rd_data = {sepc, 2'b0};
			`CSR_SCAUSE:	rd_data = {scause_irq, {(`XLEN-6){1'b0}}, scause_code};
			`CSR_STVAL:	rd_data = stval;
			`CSR_SIP:	rd_data = sip;
			`CSR_MNECYCLE:	rd_data = mnecycle;
			`CSR_SNECYCLE:	rd_data = snecycle;
			default:	rd_data = '0;
		endcase
	end

	// delegation only below M
	always_comb
	begin
		if (current_mode == MODE_M)
			trap_to_s = 1'b0;
		else if (trap_cause_irq)
			trap_to_s = mideleg[trap_cause];
		else
			trap_to_s = medeleg[trap_cause];
	end

	assign trap_vector = trap_to_s ? {stvec, 2'b0} : {mtvec, 2'b0};
	assign ret_pc_m = {mepc, 2'b0};
	assign ret_pc_s = {sepc, 2'b0};
	assign tval_pc = !trap_cause_irq && (trap_cause == `CAUSE_I_MISALIGNED);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= MODE_M;
			st_sie <= 1'b0;
			st_mie <= 1'b0;
			st_spie <= 1'b0;
			st_mpie <= 1'b0;
			st_spp <= 1'b0;
			st_mpp <= MODE_M;
			meie <= 1'b0;
			seie <= 1'b0;
			mtie <= 1'b0;
			stie <= 1'b0;
			mtvec <= '0;
			stvec <= '0;
			mepc <= '0;
			sepc <= '0;
			mscratch <= '0;
			sscratch <= '0;
			mtval <= '0;
			stval <= '0;
			mcause_irq <= 1'b0;
			mcause_code <= '0;
			scause_irq <= 1'b0;
			scause_code <= '0;
			medeleg <= '0;
			mideleg <= '0;
			mnecycle <= '1;		// timers idle
			snecycle <= '1;
		end
		else if (trap_enter && trap_to_s)
		begin
			sepc <= trap_pc[`XLEN-1:2];
			scause_irq <= trap_cause_irq;
			scause_code <= trap_cause;
			stval <= tval_pc ? trap_pc : '0;
			st_spie <= st_sie;
			st_sie <= 1'b0;
			st_spp <= current_mode[0];
			current_mode <= MODE_S;
		end
		else if (trap_enter)
		begin
			mepc <= trap_pc[`XLEN-1:2];
			mcause_irq <= trap_cause_irq;
			mcause_code <= trap_cause;
			mtval <= tval_pc ? trap_pc : '0;
			st_mpie <= st_mie;
			st_mie <= 1'b0;
			st_mpp <= current_mode;
			current_mode <= MODE_M;
		end
		else if (mret_do)
		begin
			st_mie <= st_mpie;
			st_mpie <= 1'b1;
			st_mpp <= MODE_U;	// least privileged mode
			current_mode <= st_mpp;
		end
		else if (sret_do)
		begin
			st_sie <= st_spie;
			st_spie <= 1'b1;
			st_spp <= 1'b0;
			current_mode <= st_spp ? MODE_S : MODE_U;
		end
		else if (wr_en)
		begin
			case (rd_addr)
				`CSR_MSTATUS:
				begin
					st_sie <= wr_data[1];
					st_mie <= wr_data[3];
					st_spie <= wr_data[5];
					st_mpie <= wr_data[7];
					st_spp <= wr_data[8];
					if (wr_data[12:11] != 2'b10)	// reserved encoding keeps old mpp
						st_mpp <= mode_t'(wr_data[12:11]);
				end
				`CSR_SSTATUS:
				begin
					st_sie <= wr_data[1];
					st_spie <= wr_data[5];
					st_spp <= wr_data[8];
				end
				`CSR_MIE:
				begin
					stie <= wr_data[5];
					mtie <= wr_data[7];
					seie <= wr_data[9];
					meie <= wr_data[11];
				end
				`CSR_SIE:
				begin
					stie <= wr_data[5];
					seie <= wr_data[9];
				end
				`CSR_MEDELEG:	medeleg <= wr_data & `MEDELEG_MASK;
				`CSR_MIDELEG:	mideleg <= wr_data & `MIDELEG_MASK;
				`CSR_MTVEC:	mtvec <= wr_data[`XLEN-1:2];
				`CSR_STVEC:	stvec <= wr_data[`XLEN-1:2];
				`CSR_MSCRATCH:	mscratch <= wr_data;
				`CSR_SSCRATCH:	sscratch <= wr_data;
				`CSR_MEPC:	mepc <= wr_data[`XLEN-1:2];
				`CSR_SEPC:	sepc <= wr_data[`XLEN-1:2];
				`CSR_MCAUSE:
				begin
					mcause_irq <= wr_data[`XLEN-1];
					mcause_code <= wr_data[4:0];
				end
				`CSR_SCAUSE:
				begin
					scause_irq <= wr_data[`XLEN-1];
					scause_code <= wr_data[4:0];
				end
				`CSR_MTVAL:	mtval <= wr_data;
				`CSR_STVAL:	stval <= wr_data;
				`CSR_MNECYCLE:	mnecycle <= wr_data;
				`CSR_SNECYCLE:	snecycle <= wr_data;
				default:	;	// misa, mip and unknown addresses ignore writes
			endcase
		end
	end

	// free running counter against the two compare registers
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			cycle_cnt <= '0;
			mtip <= 1'b0;
			stip <= 1'b0;
		end
		else
		begin
			cycle_cnt <= cycle_cnt + 1'b1;
			mtip <= (cycle_cnt >= mnecycle);
			stip <= (cycle_cnt >= snecycle);
		end
	end

	// global enables
	assign m_glob_en = (current_mode != MODE_M) || st_mie;
	assign s_glob_en = (current_mode == MODE_U) || ((current_mode == MODE_S) && st_sie);

	// undelegated s interrupts are taken in M and follow the M rule
	assign irq_pending[3] = m_ext_irq & meie & m_glob_en;
	assign irq_pending[2] = mtip & mtie & m_glob_en;
	assign irq_pending[1] = s_ext_irq & seie & (mideleg[9] ? s_glob_en : m_glob_en);
	assign irq_pending[0] = stip & stie & (mideleg[5] ? s_glob_en : m_glob_en);

	a_strobes_onehot: assert property (
		@(posedge clk) disable iff (!nrst)
		$onehot0({trap_enter, mret_do, sret_do})
	) else $error("trap_enter, mret_do and sret_do overlap");

	a_no_mret_in_s: assert property (
		@(posedge clk) disable iff (!nrst)
		mret_do |-> (current_mode != MODE_S)
	) else $error("mret executed in S mode");

endmodule

// File: hdl/csr_subsystem.sv
`timescale 1ns/1ps

module csr_subsystem import csr_pkg::*; (
	input logic clk, nrst,
	input logic csr_valid,
	input csr_op_t csr_op,
	input csr_addr_t csr_addr,
	input xlen_t csr_src,
	output xlen_t csr_rdata,
	input logic exc_valid,
	input cause_code_t exc_code,
	input xlen_t exc_pc,
	input logic m_ret, s_ret,
	input xlen_t cur_pc,
	input logic m_ext_irq, s_ext_irq,
	output logic redirect_valid,
	output xlen_t redirect_pc,
	output mode_t current_mode
	);

	// csr access path
	csr_addr_t rd_addr;
	xlen_t rd_data;
	logic wr_en;
	xlen_t wr_data;

	// trap path
	logic trap_enter, mret_do, sret_do;
	logic trap_cause_irq;
	cause_code_t trap_cause;
	xlen_t trap_pc;
	xlen_t trap_vector, ret_pc_m, ret_pc_s;
	logic [3:0] irq_pending;

	csr_op_unit i_csr_op_unit (
		.clk, .nrst,
		.csr_valid, .csr_op, .csr_addr, .csr_src,
		.rd_data, .rd_addr, .wr_en, .wr_data, .csr_rdata
	);

	csr_regfile i_csr_regfile (
		.clk, .nrst,
		.rd_addr, .rd_data, .wr_en, .wr_data,
		.trap_enter, .mret_do, .sret_do,
		.trap_cause_irq, .trap_cause, .trap_pc,
		.m_ext_irq, .s_ext_irq,
		.trap_vector, .ret_pc_m, .ret_pc_s,
		.irq_pending, .current_mode
	);

	trap_control i_trap_control (
		.exc_valid, .exc_code, .exc_pc,
		.m_ret, .s_ret, .csr_valid, .cur_pc,
		.irq_pending, .trap_vector, .ret_pc_m, .ret_pc_s,
		.trap_enter, .mret_do, .sret_do,
		.trap_cause_irq, .trap_cause, .trap_pc,
		.redirect_pc, .redirect_valid
	);

endmodule

// File: hdl/trap_control.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module trap_control import csr_pkg::*; (
	input logic exc_valid,
	input cause_code_t exc_code,
	input xlen_t exc_pc,
	input logic m_ret, s_ret,
	input logic csr_valid,
	input xlen_t cur_pc,
	input logic [3:0] irq_pending,
	input xlen_t trap_vector, ret_pc_m, ret_pc_s,
	output logic trap_enter, mret_do, sret_do,
	output logic trap_cause_irq,
	output cause_code_t trap_cause,
	output xlen_t trap_pc,
	output xlen_t redirect_pc,
	output logic redirect_valid
	);

	logic irq_take;
	cause_code_t irq_code;

	// interrupts wait while a csr access is in flight
	assign irq_take = !csr_valid && (|irq_pending);

	// fixed order: m ext, m timer, s ext, s timer
	always_comb
	begin
		if (irq_pending[3])
			irq_code = `IRQ_M_EXT;
		else if (irq_pending[2])
			irq_code = `IRQ_M_TIMER;
		else if (irq_pending[1])
			irq_code = `IRQ_S_EXT;
		else
			irq_code = `IRQ_S_TIMER;
	end

	always_comb
	begin
		trap_enter = 1'b0;
		mret_do = 1'b0;
		sret_do = 1'b0;
		trap_cause_irq = 1'b0;
		trap_cause = '0;
		trap_pc = '0;
		redirect_pc = '0;
		redirect_valid = 1'b0;

		if (exc_valid)
		begin
			trap_enter = 1'b1;
			trap_cause = exc_code;
			trap_pc = exc_pc;
			redirect_pc = trap_vector;	// vector follows trap_cause through the regfile
			redirect_valid = 1'b1;
		end
		else if (m_ret)
		begin
			mret_do = 1'b1;
			redirect_pc = ret_pc_m;
			redirect_valid = 1'b1;
		end
		else if (s_ret)
		begin
			sret_do = 1'b1;
			redirect_pc = ret_pc_s;
			redirect_valid = 1'b1;
		end
		else if (irq_take)
		begin
			trap_enter = 1'b1;
			trap_cause_irq = 1'b1;
			trap_cause = irq_code;
			trap_pc = cur_pc;		// resume at the interrupted instruction
			redirect_pc = trap_vector;
			redirect_valid = 1'b1;
		end
	end

endmodule

// File: project.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_op_unit.sv
hdl/csr_regfile.sv
hdl/trap_control.sv
hdl/csr_subsystem.sv
tests/csr_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module csr_subsystem_tb \
	-f project.f -o csr_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/csr_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

// File: tests/csr_subsystem_tb.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_subsystem_tb import csr_pkg::*; ();

	localparam int KIND_CSR = 0;
	localparam int KIND_EXC = 1;
	localparam int KIND_MRET = 2;
	localparam int KIND_SRET = 3;
	localparam int KIND_IRQ = 4;
	localparam int KIND_POLL = 5;
	localparam int POLL_LIMIT = 8;
	localparam int RESET_CYCLES = 3;

	logic clk, nrst;
	logic csr_valid;
	csr_op_t csr_op;
	csr_addr_t csr_addr;
	xlen_t csr_src, csr_rdata;
	logic exc_valid;
	cause_code_t exc_code;
	xlen_t exc_pc;
	logic m_ret, s_ret;
	xlen_t cur_pc;
	logic m_ext_irq, s_ext_irq;
	logic redirect_valid;
	xlen_t redirect_pc;
	mode_t current_mode;

	// step table, one entry per queue index
	string step_name[$];
	int step_kind[$];
	logic [1:0] step_op[$];
	csr_addr_t step_addr[$];
	xlen_t step_data[$];		// source, cause code or poll mask
	xlen_t step_pc[$];
	xlen_t step_exp[$];
	logic step_redirect[$];
	mode_t step_mode[$];		// mode seen while the step is applied

	// reference model
	xlen_t model_csr [0:4095];
	mode_t model_mode;
	logic [31:0] seed;

	int cycle_count;
	int timeout_limit;
	int check_errors;
	int steps_ok, steps_bad;
	int poll_steps;

	csr_subsystem i_csr_subsystem (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_rand(output xlen_t v);
		seed = lcg_next(seed);
		v = seed;
	endtask

	function automatic xlen_t rmw_result(input csr_op_t op, input xlen_t old, input xlen_t src);
		case (op)
			CSR_RW:
				return src;
			CSR_RS:
				return old | src;
			default:
				return old & ~src;
		endcase
	endfunction

	task automatic model_write(input csr_addr_t addr, input xlen_t val);
		case (addr)
			`CSR_MSTATUS:
			begin
				if (val[12:11] == 2'b10)	// reserved mpp encoding
					val[12:11] = model_csr[addr][12:11];
				model_csr[addr] = val & 32'h0000_19aa;
			end
			`CSR_MIE:	model_csr[addr] = val & 32'h0000_0aa0;
			`CSR_MEDELEG:	model_csr[addr] = val & 32'h0000_ffff;	// codes 0 to 15
			`CSR_MTVEC, `CSR_STVEC, `CSR_MEPC, `CSR_SEPC:
				model_csr[addr] = val & ~32'h3;
			`CSR_MSCRATCH, `CSR_SSCRATCH, `CSR_MNECYCLE, `CSR_SNECYCLE:
				model_csr[addr] = val;
			default:	;	// read only or unmapped
		endcase
	endtask

	// trap entry with delegation below M
	task automatic trap_entry_model(input logic irq, input cause_code_t code, input xlen_t pc,
		output xlen_t vec);
		xlen_t st;
		logic to_s;
		st = model_csr[`CSR_MSTATUS];
		to_s = (model_mode != MODE_M) &&
			(irq ? model_csr[`CSR_MIDELEG][code] : model_csr[`CSR_MEDELEG][code]);
		if (to_s)
		begin
			model_csr[`CSR_SEPC] = pc & ~32'h3;
			model_csr[`CSR_SCAUSE] = {irq, 26'b0, code};
			st[5] = st[1];
			st[1] = 1'b0;
			st[8] = (model_mode == MODE_S);
			model_mode = MODE_S;
			vec = model_csr[`CSR_STVEC];
		end
		else
		begin
			model_csr[`CSR_MEPC] = pc & ~32'h3;
			model_csr[`CSR_MCAUSE] = {irq, 26'b0, code};
			st[7] = st[3];
			st[3] = 1'b0;
			st[12:11] = model_mode;
			model_mode = MODE_M;
			vec = model_csr[`CSR_MTVEC];
		end
		model_csr[`CSR_MSTATUS] = st;
	endtask

	task automatic add_step(input string name, input int kind, input logic [1:0] op,
		input csr_addr_t addr, input xlen_t data, input xlen_t pc, input xlen_t exp,
		input logic redirect, input mode_t mode);
		step_name.push_back(name);
		step_kind.push_back(kind);
		step_op.push_back(op);
		step_addr.push_back(addr);
		step_data.push_back(data);
		step_pc.push_back(pc);
		step_exp.push_back(exp);
		step_redirect.push_back(redirect);
		step_mode.push_back(mode);
	endtask

	task automatic csr_step(input string name, input csr_op_t op, input csr_addr_t addr,
		input xlen_t src);
		xlen_t old;
		old = model_csr[addr];
		add_step(name, KIND_CSR, op, addr, src, '0, old, 1'b0, model_mode);
		if (op == CSR_RW || src != '0)		// set or clear with zero does not write
			model_write(addr, rmw_result(op, old, src));
	endtask

	task automatic exc_step(input string name, input cause_code_t code, input xlen_t pc);
		mode_t mode;
		xlen_t vec;
		mode = model_mode;
		trap_entry_model(1'b0, code, pc, vec);
		add_step(name, KIND_EXC, CSR_RS, '0, {27'b0, code}, pc, vec, 1'b1, mode);
	endtask

	task automatic mret_step(input string name);
		mode_t mode;
		xlen_t st;
		mode = model_mode;
		st = model_csr[`CSR_MSTATUS];
		st[3] = st[7];
		st[7] = 1'b1;
		model_mode = mode_t'(st[12:11]);
		st[12:11] = MODE_U;
		model_csr[`CSR_MSTATUS] = st;
		add_step(name, KIND_MRET, CSR_RS, '0, '0, '0, model_csr[`CSR_MEPC], 1'b1, mode);
	endtask

	task automatic sret_step(input string name);
		mode_t mode;
		xlen_t st;
		mode = model_mode;
		st = model_csr[`CSR_MSTATUS];
		st[1] = st[5];
		st[5] = 1'b1;
		model_mode = st[8] ? MODE_S : MODE_U;
		st[8] = 1'b0;
		model_csr[`CSR_MSTATUS] = st;
		add_step(name, KIND_SRET, CSR_RS, '0, '0, '0, model_csr[`CSR_SEPC], 1'b1, mode);
	endtask

	// M external interrupt under the M global enable rule
	task automatic irq_step(input string name, input xlen_t pc);
		mode_t mode;
		xlen_t vec;
		logic take;
		mode = model_mode;
		vec = '0;
		take = model_csr[`CSR_MIE][11] &&
			(model_mode != MODE_M || model_csr[`CSR_MSTATUS][3]);
		if (take)
			trap_entry_model(1'b1, `IRQ_M_EXT, pc, vec);
		add_step(name, KIND_IRQ, CSR_RS, '0, '0, pc, vec, take, mode);
	endtask

	task automatic poll_step(input string name, input csr_addr_t addr, input xlen_t mask,
		input xlen_t exp);
		add_step(name, KIND_POLL, CSR_RS, addr, mask, '0, exp, 1'b0, model_mode);
		poll_steps++;
	endtask

	task automatic build_table();
		xlen_t r;
		next_rand(r);
		csr_step("mscratch rw", CSR_RW, `CSR_MSCRATCH, r);
		next_rand(r);
		csr_step("mscratch rs", CSR_RS, `CSR_MSCRATCH, r);
		next_rand(r);
		csr_step("mscratch rc", CSR_RC, `CSR_MSCRATCH, r);
		csr_step("mscratch rs zero", CSR_RS, `CSR_MSCRATCH, '0);
		csr_step("mscratch rc zero", CSR_RC, `CSR_MSCRATCH, '0);
		csr_step("mscratch read", CSR_RS, `CSR_MSCRATCH, '0);
		next_rand(r);
		csr_step("sscratch rw", CSR_RW, `CSR_SSCRATCH, r);
		next_rand(r);
		csr_step("sscratch rc", CSR_RC, `CSR_SSCRATCH, r);
		next_rand(r);
		csr_step("sscratch rs", CSR_RS, `CSR_SSCRATCH, r);
		csr_step("sscratch read", CSR_RS, `CSR_SSCRATCH, '0);
		// warl fields
		csr_step("mtvec rw", CSR_RW, `CSR_MTVEC, 32'h0000_1003);
		csr_step("mtvec read", CSR_RS, `CSR_MTVEC, '0);
		csr_step("mepc rw", CSR_RW, `CSR_MEPC, 32'h0000_2006);
		csr_step("mepc read", CSR_RS, `CSR_MEPC, '0);
		csr_step("misa rw", CSR_RW, `CSR_MISA, 32'hffff_ffff);
		csr_step("misa read", CSR_RS, `CSR_MISA, '0);
		csr_step("unknown rw", CSR_RW, 12'h7ff, 32'h1234_5678);
		csr_step("unknown read", CSR_RS, 12'h7ff, '0);
		// undelegated exception in M
		csr_step("mstatus set mie", CSR_RS, `CSR_MSTATUS, 32'h8);
		exc_step("ecall from m", `CAUSE_ECALL_M, 32'h0000_3000);
		csr_step("mepc after trap", CSR_RS, `CSR_MEPC, '0);
		csr_step("mcause after trap", CSR_RS, `CSR_MCAUSE, '0);
		csr_step("mstatus after trap", CSR_RS, `CSR_MSTATUS, '0);
		mret_step("mret to m");
		csr_step("mstatus after mret", CSR_RS, `CSR_MSTATUS, '0);
		// delegated ecall from S
		csr_step("stvec rw", CSR_RW, `CSR_STVEC, 32'h0000_4000);
		csr_step("medeleg ecall s", CSR_RW, `CSR_MEDELEG, 32'h1 << `CAUSE_ECALL_S);
		csr_step("mepc for mret", CSR_RW, `CSR_MEPC, 32'h0000_5000);
		csr_step("mstatus mpp s", CSR_RS, `CSR_MSTATUS, 32'h0000_0800);
		mret_step("mret to s");
		exc_step("ecall from s", `CAUSE_ECALL_S, 32'h0000_6000);
		csr_step("sepc after trap", CSR_RS, `CSR_SEPC, '0);
		csr_step("scause after trap", CSR_RS, `CSR_SCAUSE, '0);
		csr_step("mstatus spp", CSR_RS, `CSR_MSTATUS, '0);
		sret_step("sret to s");
		exc_step("illegal to m", `CAUSE_ILLEGAL, 32'h0000_7000);
		// interrupts
		csr_step("mie meie", CSR_RW, `CSR_MIE, 32'h0000_0800);
		csr_step("mstatus set mie again", CSR_RS, `CSR_MSTATUS, 32'h8);
		irq_step("m ext irq taken", 32'h0000_8000);
		csr_step("mcause irq", CSR_RS, `CSR_MCAUSE, '0);
		csr_step("mepc irq", CSR_RS, `CSR_MEPC, '0);
		irq_step("m ext irq masked", 32'h0000_9000);
		// machine timer
		csr_step("mnecycle small", CSR_RW, `CSR_MNECYCLE, 32'd10);
		poll_step("mtip set", `CSR_MIP, 32'h80, 32'h80);
		csr_step("mnecycle idle", CSR_RW, `CSR_MNECYCLE, '1);
		poll_step("mtip clear", `CSR_MIP, 32'h80, 32'h0);
	endtask

	task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %h, actual %h", what, expected, actual);
			check_errors++;
		end
	endtask

	task automatic apply_inputs(input int i);
		csr_valid <= (step_kind[i] == KIND_CSR) || (step_kind[i] == KIND_POLL);
		csr_op <= csr_op_t'(step_op[i]);
		csr_addr <= step_addr[i];
		csr_src <= (step_kind[i] == KIND_CSR) ? step_data[i] : '0;
		exc_valid <= (step_kind[i] == KIND_EXC);
		exc_code <= step_data[i][4:0];
		exc_pc <= step_pc[i];
		m_ret <= (step_kind[i] == KIND_MRET);
		s_ret <= (step_kind[i] == KIND_SRET);
		m_ext_irq <= (step_kind[i] == KIND_IRQ);
		cur_pc <= step_pc[i];
	endtask

	task automatic run_step(input int i);
		int tries;
		int errs_before;
		xlen_t seen;
		errs_before = check_errors;
		tries = 0;
		seen = '0;
		// a poll repeats its read until the masked value shows up
		do
		begin
			@(posedge clk);
			apply_inputs(i);
			@(negedge clk);
			seen = csr_rdata & step_data[i];
			tries++;
		end
		while (step_kind[i] == KIND_POLL && seen != step_exp[i] && tries < POLL_LIMIT);
		check_value({step_name[i], " mode"}, {30'b0, step_mode[i]}, {30'b0, current_mode});
		check_value({step_name[i], " redirect_valid"}, {31'b0, step_redirect[i]},
			{31'b0, redirect_valid});
		if (step_kind[i] == KIND_CSR)
			check_value(step_name[i], step_exp[i], csr_rdata);
		else if (step_kind[i] == KIND_POLL)
			check_value(step_name[i], step_exp[i], seen);
		else if (step_redirect[i])
			check_value({step_name[i], " redirect_pc"}, step_exp[i], redirect_pc);
		if (check_errors == errs_before)
		begin
			steps_ok++;
			$display("%s: ok", step_name[i]);
		end
		else
		begin
			steps_bad++;
			$display("%s: mismatch", step_name[i]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		csr_valid = 1'b0;
		csr_op = CSR_RS;
		csr_addr = '0;
		csr_src = '0;
		exc_valid = 1'b0;
		exc_code = '0;
		exc_pc = '0;
		m_ret = 1'b0;
		s_ret = 1'b0;
		cur_pc = '0;
		m_ext_irq = 1'b0;
		s_ext_irq = 1'b0;
		cycle_count = 0;
		timeout_limit = 0;
		check_errors = 0;
		steps_ok = 0;
		steps_bad = 0;
		poll_steps = 0;
		seed = 32'heb17;
		for (int a = 0; a < 4096; a++)
			model_csr[a] = '0;
		model_csr[`CSR_MSTATUS] = 32'h0000_1800;	// mpp comes up as M
		model_csr[`CSR_MISA] = 32'h4004_1100;	// mxl 32, extensions i, m and s
		model_csr[`CSR_MNECYCLE] = '1;
		model_csr[`CSR_SNECYCLE] = '1;
		model_mode = MODE_M;
		build_table();
		timeout_limit = step_name.size() * 4 + poll_steps * POLL_LIMIT + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		nrst <= 1'b1;
		foreach (step_name[i])
			run_step(i);
		$display("%0d steps ok, %0d with errors", steps_ok, steps_bad);
		if (steps_bad == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
